// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_icache
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS PASSED" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cache_array.sv ====
`default_nettype none

module cache_array #(
  parameter type         entry_t        = icache_pkg::word_t,
  parameter int unsigned DEPTH          = 2048,
  parameter bit          CLEAR_ON_RESET = 1'b0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
  input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
  input  logic                     wr_en_i,
  input  entry_t                   wr_data_i,
  output entry_t                   rd_data_o,
  output logic                     init_done_o
);

  localparam int unsigned AW = $clog2(DEPTH);

  entry_t        mem [DEPTH];
  logic [AW-1:0] clr_addr;
  logic          clearing;

  // invalidation walk after reset, one entry per cycle
  // without clearing the array is usable straight out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      clearing    <= CLEAR_ON_RESET;
      init_done_o <= !CLEAR_ON_RESET;
      clr_addr    <= '0;
    end else if (clearing) begin
      clr_addr <= clr_addr + 1'b1;
      if (clr_addr == AW'(DEPTH - 1)) begin
        clearing    <= 1'b0;
        init_done_o <= 1'b1;
      end
    end
  end

  // single write port, the walk owns it while clearing
  // read data registered, valid one cycle after the address
  always_ff @(posedge clk) begin
    if (clearing) begin
      mem[clr_addr] <= '0;
    end else if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
    rd_data_o <= mem[rd_addr_i];
  end

  // the owner of the write port must hold off until the walk ends
  a_no_early_write: assert property (@(posedge clk) disable iff (rst)
    wr_en_i |-> init_done_o);

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
icache_pkg.sv
cache_array.sv
icache_ctrl.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

// ==== icache_consts.svh ====
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// fetch address and instruction word width
`define ICACHE_XLEN 32

// address split
// tag | index | word offset | byte
// 19  |   7   |      4      |  2
`define ICACHE_TAG_W   19
`define ICACHE_INDEX_W 7
`define ICACHE_WORD_W  4
`define ICACHE_BYTE_W  2

// 8 KB direct mapped, 64 byte lines
`define ICACHE_LINES          128
`define ICACHE_WORDS_PER_LINE 16

// memory burst length field, beats minus one
// full line refill
`define ICACHE_BURST_LEN  8'd15
// one word for the uncached path
`define ICACHE_SINGLE_LEN 8'd0

// everything below this bound bypasses the cache
// (boot rom and device space live there)
`define ICACHE_UNCACHED_LIMIT 32'h8000_0000

// memory contents rule
// word at address a reads back as a ^ pattern
`define ICACHE_MEM_PATTERN 32'h5a3c_96e1

`endif

// ==== icache_ctrl.sv ====
`default_nettype none

`include "icache_consts.svh"

module icache_ctrl (
  input  logic                                        clk,
  input  logic                                        rst,
  // fetch request
  input  logic                                        req_valid_i,
  input  icache_pkg::addr_t                           req_addr_i,
  input  logic                                        is_uncached_i,
  output logic                                        req_ready_o,
  // tag store
  input  icache_pkg::tag_entry_t                      tag_rd_i,
  input  logic                                        init_done_i,
  output icache_pkg::index_t                          tag_rd_index_o,
  output icache_pkg::index_t                          tag_wr_index_o,
  output logic                                        tag_wr_en_o,
  output icache_pkg::tag_entry_t                      tag_wr_o,
  // word store
  output logic [`ICACHE_INDEX_W+`ICACHE_WORD_W-1:0]   data_rd_addr_o,
  output logic [`ICACHE_INDEX_W+`ICACHE_WORD_W-1:0]   data_wr_addr_o,
  output logic                                        data_wr_en_o,
  // memory request
  output logic                                        mem_req_valid_o,
  output icache_pkg::addr_t                           mem_addr_o,
  output icache_pkg::beat_len_t                       mem_len_o,
  input  logic                                        mem_rvalid_i,
  input  icache_pkg::word_t                           mem_rdata_i,
  // result sources
  output logic                                        hit_o,
  output logic                                        uncached_valid_o,
  output icache_pkg::word_t                           uncached_word_o
);

  icache_pkg::ctrl_state_t state_q;

  // fields of the incoming address with byte bits ignored
  icache_pkg::tag_t   req_tag;
  icache_pkg::index_t req_index;
  icache_pkg::woff_t  req_woff;

  // fields of the fetch in flight
  icache_pkg::tag_t   tag_q;
  icache_pkg::index_t index_q;
  icache_pkg::woff_t  woff_q;
  logic               uncached_q;

  // refill beats taken so far
  icache_pkg::beat_len_t beat_cnt;

  logic accept;
  logic beat;
  logic last_beat;
  logic tag_match;

  assign {req_tag, req_index, req_woff} = req_addr_i[`ICACHE_XLEN-1:`ICACHE_BYTE_W];

  // accept only when idle and the tag walk is over
  assign req_ready_o = (state_q == icache_pkg::IDLE) && init_done_i;
  assign accept      = req_valid_i && req_ready_o;

  // one beat per edge with request and data valid both high
  assign beat      = mem_req_valid_o && mem_rvalid_i;
  assign last_beat = beat && (beat_cnt == mem_len_o);

  // stored entry against registered tag
  assign tag_match = tag_rd_i[`ICACHE_TAG_W] && (tag_rd_i[`ICACHE_TAG_W-1:0] == tag_q);
  assign hit_o     = (state_q == icache_pkg::LOOKUP) && !uncached_q && tag_match;

  // array reads
  // idle reads straight from the request so lookup sees the data
  // other states read the held fetch (reread after refill)
  assign tag_rd_index_o = (state_q == icache_pkg::IDLE) ? req_index : index_q;
  assign data_rd_addr_o = (state_q == icache_pkg::IDLE) ? {req_index, req_woff}
                                                        : {index_q, woff_q};

  // refill writes one word per beat in burst order
  assign data_wr_en_o   = beat && (state_q == icache_pkg::REFILL);
  assign data_wr_addr_o = {index_q, beat_cnt[`ICACHE_WORD_W-1:0]};

  // tag written with the final word
  assign tag_wr_en_o    = last_beat && (state_q == icache_pkg::REFILL);
  assign tag_wr_index_o = index_q;
  assign tag_wr_o       = {1'b1, tag_q};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q          <= icache_pkg::IDLE;
      mem_req_valid_o  <= 1'b0;
      uncached_valid_o <= 1'b0;
      beat_cnt         <= '0;
    end else begin
      // single cycle pulse after the uncached beat
      uncached_valid_o <= (state_q == icache_pkg::UNCACHED) && beat;
      case (state_q)
        icache_pkg::IDLE: begin
          if (accept) begin
            state_q <= icache_pkg::LOOKUP;
          end
        end
        icache_pkg::LOOKUP: begin
          beat_cnt <= '0;
          if (hit_o) begin
            state_q <= icache_pkg::IDLE;
          end else if (uncached_q) begin
            state_q         <= icache_pkg::UNCACHED;
            mem_req_valid_o <= 1'b1;
          end else begin
            state_q         <= icache_pkg::REFILL;
            mem_req_valid_o <= 1'b1;
          end
        end
        icache_pkg::REFILL: begin
          if (last_beat) begin
            mem_req_valid_o <= 1'b0;
            state_q         <= icache_pkg::REREAD;
          end else if (beat) begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        icache_pkg::REREAD: begin
          // arrays pick up the fresh line, lookup then hits
          state_q <= icache_pkg::LOOKUP;
        end
        icache_pkg::UNCACHED: begin
          if (beat) begin
            mem_req_valid_o <= 1'b0;
          end
          // leave together with the result pulse
          if (uncached_valid_o) begin
            state_q <= icache_pkg::IDLE;
          end
        end
        default: begin
          state_q <= icache_pkg::IDLE;
        end
      endcase
    end
  end

  // fetch fields and request payload
  always_ff @(posedge clk) begin
    if (accept) begin
      tag_q      <= req_tag;
      index_q    <= req_index;
      woff_q     <= req_woff;
      uncached_q <= is_uncached_i;
    end
    if ((state_q == icache_pkg::LOOKUP) && !hit_o) begin
      if (uncached_q) begin
        // one beat at the word address
        mem_addr_o <= {tag_q, index_q, woff_q, `ICACHE_BYTE_W'(0)};
        mem_len_o  <= `ICACHE_SINGLE_LEN;
      end else begin
        // whole line from the line base
        mem_addr_o <= {tag_q, index_q, (`ICACHE_WORD_W + `ICACHE_BYTE_W)'(0)};
        mem_len_o  <= `ICACHE_BURST_LEN;
      end
    end
    if ((state_q == icache_pkg::UNCACHED) && beat) begin
      uncached_word_o <= mem_rdata_i;
    end
  end

  // request stays up until the final beat
  a_req_held: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid_o && !last_beat |=> mem_req_valid_o);

  // a hit never needs memory
  a_hit_no_req: assert property (@(posedge clk) disable iff (rst)
    !(hit_o && mem_req_valid_o));

  // beat count stays inside the requested burst
  a_beat_bound: assert property (@(posedge clk) disable iff (rst)
    (state_q inside {icache_pkg::REFILL, icache_pkg::UNCACHED}) && mem_req_valid_o
    |-> (beat_cnt <= mem_len_o));

endmodule

`default_nettype wire

// ==== icache_pkg.sv ====
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

  // fetch side and memory side address
  typedef logic [`ICACHE_XLEN-1:0] addr_t;

  // one instruction word
  typedef logic [`ICACHE_XLEN-1:0] word_t;

  // address fields
  typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] index_t;
  typedef logic [`ICACHE_WORD_W-1:0]  woff_t;

  // memory burst length, beats minus one
  typedef logic [7:0] beat_len_t;

  // tag store entry
  // msb is the valid bit, low bits hold the tag
  typedef logic [`ICACHE_TAG_W:0] tag_entry_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL,
    REREAD,
    UNCACHED
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== icache_stim.txt ====
# fetch address, expected word (address xor 5a3c96e1), expected line fills so far
# one fetch per line, hex hex decimal
80001040 da3c86a1 1
80001044 da3c86a5 1
8000107c da3c869d 1
80003040 da3ca6a1 2
80001040 da3c86a1 3
80001048 da3c86a9 3
00002000 5a3cb6e1 3
00002000 5a3cb6e1 3
00000104 5a3c97e5 3
80002000 da3cb6e1 4
8000203c da3cb6dd 4
80010f80 da3d9961 5
80010fbc da3d995d 5
ffffffc0 a5c36921 6
fffffffc a5c3691d 6
7ffffffc 25c3691d 6
80001080 da3c8661 7
80003044 da3ca6a5 8
80001064 da3c8685 9
80002004 da3cb6e5 9

// ==== icache_top.sv ====
`default_nettype none

`include "icache_consts.svh"

module icache_top (
  input  logic                  clk,
  input  logic                  rst,
  // fetch unit side
  input  logic                  req_valid_i,
  input  icache_pkg::addr_t     req_addr_i,
  output logic                  req_ready_o,
  output logic                  rdata_valid_o,
  output icache_pkg::word_t     rdata_o,
  // memory side
  output logic                  mem_req_valid_o,
  output icache_pkg::addr_t     mem_addr_o,
  output icache_pkg::beat_len_t mem_len_o,
  input  logic                  mem_rvalid_i,
  input  icache_pkg::word_t     mem_rdata_i
);

  localparam int unsigned WORDS = `ICACHE_LINES * `ICACHE_WORDS_PER_LINE;
  localparam int unsigned DA_W  = `ICACHE_INDEX_W + `ICACHE_WORD_W;

  logic                   is_uncached;

  // tag store ports
  icache_pkg::index_t     tag_rd_index;
  icache_pkg::index_t     tag_wr_index;
  logic                   tag_wr_en;
  icache_pkg::tag_entry_t tag_wr;
  icache_pkg::tag_entry_t tag_rd;
  logic                   tag_init_done;

  // word store ports
  logic [DA_W-1:0]        data_rd_addr;
  logic [DA_W-1:0]        data_wr_addr;
  logic                   data_wr_en;
  icache_pkg::word_t      word_rd;
  logic                   word_init_done;

  // result sources
  logic                   hit;
  logic                   uncached_valid;
  icache_pkg::word_t      uncached_word;

  // low region bypasses the cache
  assign is_uncached = (req_addr_i < `ICACHE_UNCACHED_LIMIT);

  icache_ctrl u_ctrl (
    .clk              (clk),
    .rst              (rst),
    .req_valid_i      (req_valid_i),
    .req_addr_i       (req_addr_i),
    .is_uncached_i    (is_uncached),
    .req_ready_o      (req_ready_o),
    .tag_rd_i         (tag_rd),
    .init_done_i      (tag_init_done && word_init_done),
    .tag_rd_index_o   (tag_rd_index),
    .tag_wr_index_o   (tag_wr_index),
    .tag_wr_en_o      (tag_wr_en),
    .tag_wr_o         (tag_wr),
    .data_rd_addr_o   (data_rd_addr),
    .data_wr_addr_o   (data_wr_addr),
    .data_wr_en_o     (data_wr_en),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_addr_o       (mem_addr_o),
    .mem_len_o        (mem_len_o),
    .mem_rvalid_i     (mem_rvalid_i),
    .mem_rdata_i      (mem_rdata_i),
    .hit_o            (hit),
    .uncached_valid_o (uncached_valid),
    .uncached_word_o  (uncached_word)
  );

  // one entry per line, invalidated after reset
  cache_array #(
    .entry_t        (icache_pkg::tag_entry_t),
    .DEPTH          (`ICACHE_LINES),
    .CLEAR_ON_RESET (1'b1)
  ) u_tag_store (
    .clk         (clk),
    .rst         (rst),
    .rd_addr_i   (tag_rd_index),
    .wr_addr_i   (tag_wr_index),
    .wr_en_i     (tag_wr_en),
    .wr_data_i   (tag_wr),
    .rd_data_o   (tag_rd),
    .init_done_o (tag_init_done)
  );

  // one entry per word, filled straight from the burst
  // stale contents are masked by the tag valid bit
  cache_array #(
    .entry_t        (icache_pkg::word_t),
    .DEPTH          (WORDS),
    .CLEAR_ON_RESET (1'b0)
  ) u_word_store (
    .clk         (clk),
    .rst         (rst),
    .rd_addr_i   (data_rd_addr),
    .wr_addr_i   (data_wr_addr),
    .wr_en_i     (data_wr_en),
    .wr_data_i   (mem_rdata_i),
    .rd_data_o   (word_rd),
    .init_done_o (word_init_done)
  );

  // result register, one cycle pulse, no back-pressure
  always_ff @(posedge clk) begin
    if (rst) begin
      rdata_valid_o <= 1'b0;
    end else begin
      rdata_valid_o <= hit || uncached_valid;
    end
  end

  // hit takes the word store, uncached return takes the captured beat
  always_ff @(posedge clk) begin
    if (hit) begin
      rdata_o <= word_rd;
    end else if (uncached_valid) begin
      rdata_o <= uncached_word;
    end
  end

endmodule

`default_nettype wire

// ==== tb_icache.sv ====
`default_nettype none

`include "icache_consts.svh"

module tb_icache;

  logic                  clk;
  logic                  rst;
  logic                  req_valid_i;
  icache_pkg::addr_t     req_addr_i;
  logic                  req_ready_o;
  logic                  rdata_valid_o;
  icache_pkg::word_t     rdata_o;
  logic                  mem_req_valid;
  icache_pkg::addr_t     mem_addr;
  icache_pkg::beat_len_t mem_len;
  logic                  mem_rvalid;
  icache_pkg::word_t     mem_rdata;
  int                    fill_count;
  int                    proto_errors;

  // stim lines hold address, expected word and expected fills so far
  icache_pkg::addr_t stim_addr[$];
  icache_pkg::word_t stim_word[$];
  int                stim_fills[$];
  bit                stim_loaded = 1'b0;

  int word_errs   = 0;
  int count_errs  = 0;
  int timing_errs = 0;
  int misc_errs   = 0;

  icache_top DUT (
    .clk             (clk),
    .rst             (rst),
    .req_valid_i     (req_valid_i),
    .req_addr_i      (req_addr_i),
    .req_ready_o     (req_ready_o),
    .rdata_valid_o   (rdata_valid_o),
    .rdata_o         (rdata_o),
    .mem_req_valid_o (mem_req_valid),
    .mem_addr_o      (mem_addr),
    .mem_len_o       (mem_len),
    .mem_rvalid_i    (mem_rvalid),
    .mem_rdata_i     (mem_rdata)
  );

  tb_mem_model u_mem (
    .clk             (clk),
    .rst             (rst),
    .mem_req_valid_i (mem_req_valid),
    .mem_addr_i      (mem_addr),
    .mem_len_i       (mem_len),
    .mem_rvalid_o    (mem_rvalid),
    .mem_rdata_o     (mem_rdata),
    .fill_count_o    (fill_count),
    .proto_errors_o  (proto_errors)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_word(input string name, input icache_pkg::word_t exp,
                            input icache_pkg::word_t act);
    if (act !== exp) begin
      word_errs++;
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      count_errs++;
      $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      timing_errs++;
      $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  // lines that do not parse as three fields are comments
  task automatic load_stim();
    int                fd;
    int                rc;
    string             line;
    icache_pkg::addr_t a;
    icache_pkg::word_t w;
    int                n;
    fd = $fopen("icache_stim.txt", "r");
    if (fd == 0) begin
      misc_errs++;
      $display("could not open icache_stim.txt for reading");
    end else begin
      while (!$feof(fd)) begin
        rc = $fgets(line, fd);
        if (rc > 0 && $sscanf(line, "%h %h %d", a, w, n) == 3) begin
          stim_addr.push_back(a);
          stim_word.push_back(w);
          stim_fills.push_back(n);
        end
      end
      $fclose(fd);
    end
    if (stim_addr.size() == 0) begin
      misc_errs++;
      $display("no fetches were read from icache_stim.txt");
    end
  endtask

  // tag walk after reset
  // nothing may leave the cache meanwhile
  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (req_ready_o !== 1'b1 && cycles < 4 * `ICACHE_LINES) begin
      @(negedge clk);
      cycles++;
      if (rdata_valid_o !== 1'b0 || mem_req_valid !== 1'b0) begin
        misc_errs++;
        $display("result or memory request seen while the tag store was clearing");
      end
    end
    if (req_ready_o !== 1'b1) begin
      misc_errs++;
      $display("cache did not become ready after reset");
    end else if (cycles < `ICACHE_LINES) begin
      // the walk clears one tag entry per cycle
      misc_errs++;
      $display("req_ready_o rose after %0d cycles, before the tag store could be cleared",
               cycles);
    end
    @(posedge clk);
    #1;
  endtask

  // entered and left 1 time unit after a rising edge
  task automatic run_fetch(input icache_pkg::addr_t addr, input icache_pkg::word_t exp_word,
                           input int exp_fills, input bit exp_hit);
    bit accepted;
    bit done;
    int lat;
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    accepted    = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = (req_ready_o === 1'b1);
      @(posedge clk);
      #1;
    end
    req_valid_i = 1'b0;
    lat  = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      lat++;
      if (rdata_valid_o === 1'b1) begin
        done = 1'b1;
        check_word("rdata_o", exp_word, rdata_o);
        check_count("fill_count", exp_fills, fill_count);
        if (exp_hit) begin
          check_latency("hit latency", 2, lat);
        end else if (lat <= 2) begin
          timing_errs++;
          $display("fetch of %h came back as a hit but needed a memory read", addr);
        end
      end else if (req_ready_o !== 1'b0) begin
        timing_errs++;
        $display("req_ready_o went high before the result of fetch %h", addr);
      end
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    int total;
    int prev_fills;
    bit hit;
    rst         = 1'b1;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    load_stim();
    stim_loaded = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    wait_ready();
    prev_fills = 0;
    foreach (stim_addr[i]) begin
      // same fill count on a cached address means a hit
      hit = (stim_addr[i] >= `ICACHE_UNCACHED_LIMIT) && (stim_fills[i] == prev_fills);
      run_fetch(stim_addr[i], stim_word[i], stim_fills[i], hit);
      prev_fills = stim_fills[i];
    end
    total = word_errs + count_errs + timing_errs + misc_errs + proto_errors;
    $display("errors: word %0d, fill count %0d, timing %0d, other %0d, memory protocol %0d",
             word_errs, count_errs, timing_errs, misc_errs, proto_errors);
    if (total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // budget of 400 cycles per fetch plus the tag walk
  initial begin
    wait (stim_loaded);
    repeat (stim_addr.size() * 400 + 4 * `ICACHE_LINES) @(posedge clk);
    $display("timeout: the fetches did not finish within their cycle budget");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
`default_nettype none

`include "icache_consts.svh"

module tb_mem_model (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  mem_req_valid_i,
  input  icache_pkg::addr_t     mem_addr_i,
  input  icache_pkg::beat_len_t mem_len_i,
  output logic                  mem_rvalid_o,
  output icache_pkg::word_t     mem_rdata_o,
  output int                    fill_count_o,
  output int                    proto_errors_o
);

  logic              rvalid_q = 1'b0;
  icache_pkg::word_t rdata_q  = '0;
  int                fills_q  = 0;
  int                errs_q   = 0;
  logic [31:0]       rng      = 32'h7de504d5;

  // burst being served
  bit                in_burst  = 1'b0;
  icache_pkg::addr_t burst_addr;
  int                burst_len = 0;
  int                next_beat = 0;

  assign mem_rvalid_o   = rvalid_q;
  assign mem_rdata_o    = rdata_q;
  assign fill_count_o   = fills_q;
  assign proto_errors_o = errs_q;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // contents rule, byte bits dropped
  function automatic icache_pkg::word_t word_at(input icache_pkg::addr_t a);
    return {a[31:2], 2'b00} ^ `ICACHE_MEM_PATTERN;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      in_burst  = 1'b0;
      next_beat = 0;
    end else begin
      if (mem_req_valid_i && !in_burst) begin
        in_burst   = 1'b1;
        burst_addr = mem_addr_i;
        burst_len  = int'(mem_len_i);
        if (mem_len_i == `ICACHE_BURST_LEN) begin
          fills_q++;
        end else if (mem_len_i != `ICACHE_SINGLE_LEN) begin
          errs_q++;
          $display("memory request with unexpected length %0d", mem_len_i);
        end
      end else if (in_burst && mem_req_valid_i) begin
        if (mem_addr_i != burst_addr || int'(mem_len_i) != burst_len) begin
          errs_q++;
          $display("memory address or length changed in the middle of a burst");
        end
      end else if (in_burst && !mem_req_valid_i) begin
        if (next_beat != burst_len + 1) begin
          errs_q++;
          $display("memory request dropped after %0d of %0d beats", next_beat, burst_len + 1);
        end
        in_burst  = 1'b0;
        next_beat = 0;
      end
      if (mem_req_valid_i && rvalid_q) begin
        if (next_beat > burst_len) begin
          errs_q++;
          $display("memory request still high after the last beat");
        end
        next_beat++;
      end
    end
    // answer just after the edge, about one cycle in four is a gap
    #1;
    rng      = xorshift32(rng);
    rvalid_q = (mem_req_valid_i === 1'b1) && (rng[1:0] != 2'b00);
    rdata_q  = word_at(mem_addr_i + (32'(next_beat) << 2));
  end

endmodule

`default_nettype wire
